/* src/stbuf_pkg.sv */
`default_nettype none

package stbuf_pkg;

  // --------------------
  // Word geometry
  // --------------------
  localparam int PADDR_W  = 32;
  localparam int DATA_W   = 64;  // One store word
  localparam int DATA_B   = DATA_W / 8;
  localparam int WORD_OFS = 3;   // Byte offset inside the word
  localparam int WADDR_W  = PADDR_W - WORD_OFS;

  // --------------------
  // Entry state machine
  // --------------------
  typedef enum logic [2:0] {
    ST_BUF_INIT,
    ST_BUF_RD_L1D,       // Waiting for read accept
    ST_BUF_RESP_L1D,     // Waiting for read hit/miss
    ST_BUF_REFILL,       // Waiting for refill accept
    ST_BUF_WAIT_REFILL,
    ST_BUF_L1D_UPDATE,   // Waiting for write accept
    ST_BUF_UPD_RESP,
    ST_BUF_WAIT_FINISH
  } st_buffer_state_t;

  // Pending store word as seen by control and forwarding
  typedef struct packed {
    logic               valid;
    logic [WADDR_W-1:0] waddr;
    logic [DATA_W-1:0]  data;
    logic [DATA_B-1:0]  strb;
  } st_buffer_entry_t;

endpackage

`default_nettype wire

/* src/stbuf_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module stbuf_entry
  import stbuf_pkg::*;
(
  input  wire logic               i_clk,
  input  wire logic               i_reset_n,

  // Store side, driven by the control module
  input  wire logic               i_load,
  input  wire logic               i_merge_accept,
  input  wire logic [PADDR_W-1:0] i_st_paddr,
  input  wire logic [DATA_W-1:0]  i_st_data,
  input  wire logic [DATA_B-1:0]  i_st_strb,

  // L1D read
  input  wire logic               i_rd_accepted,
  input  wire logic               i_rd_resp,
  input  wire logic               i_rd_hit,

  // L1D write
  input  wire logic               i_wr_accepted,
  input  wire logic               i_wr_resp,
  input  wire logic               i_wr_hit,

  // Refill
  input  wire logic               i_refill_accepted,
  input  wire logic               i_refill_done,
  input  wire logic [PADDR_W-1:0] i_refill_addr,

  output logic                    o_rd_req,
  output logic                    o_wr_req,
  output logic                    o_refill_req,
  output logic                    o_mergeable,
  output st_buffer_entry_t        o_entry
);

  st_buffer_state_t   r_state;
  st_buffer_state_t   w_state_next;

  logic [WADDR_W-1:0] r_waddr;
  logic [DATA_W-1:0]  r_data;
  logic [DATA_B-1:0]  r_strb;

  logic               w_valid;
  logic               w_refill_match;

  assign w_valid        = (r_state != ST_BUF_INIT);
  assign w_refill_match = i_refill_done &
                          (i_refill_addr[PADDR_W-1:WORD_OFS] == r_waddr);

  // --------------------
  // Payload and byte merge
  // --------------------
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_waddr <= i_st_paddr[PADDR_W-1:WORD_OFS];
      r_data  <= i_st_data;
      r_strb  <= i_st_strb;
    end else if (i_merge_accept) begin
      r_strb <= r_strb | i_st_strb;
      for (int b = 0; b < DATA_B; b++) begin
        if (i_st_strb[b]) begin
          r_data[b*8 +: 8] <= i_st_data[b*8 +: 8];  // Newer byte wins
        end
      end
    end
  end

  // --------------------
  // Request FSM
  // --------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_BUF_INIT;
    end else begin
      r_state <= w_state_next;
    end
  end

  always_comb begin
    w_state_next = r_state;
    case (r_state)
      ST_BUF_INIT: begin
        if (i_load) begin
          w_state_next = ST_BUF_RD_L1D;
        end
      end
      ST_BUF_RD_L1D: begin
        if (i_rd_accepted) begin
          w_state_next = ST_BUF_RESP_L1D;
        end
      end
      ST_BUF_RESP_L1D: begin
        if (i_rd_resp) begin
          w_state_next = i_rd_hit ? ST_BUF_L1D_UPDATE : ST_BUF_REFILL;
        end
      end
      ST_BUF_REFILL: begin
        // Line may already be back through another entry's refill
        if (i_refill_accepted) begin
          w_state_next = w_refill_match ? ST_BUF_RD_L1D : ST_BUF_WAIT_REFILL;
        end
      end
      ST_BUF_WAIT_REFILL: begin
        if (w_refill_match) begin
          w_state_next = ST_BUF_RD_L1D;  // Replay the read
        end
      end
      ST_BUF_L1D_UPDATE: begin
        if (i_wr_accepted) begin
          w_state_next = ST_BUF_UPD_RESP;
        end
      end
      ST_BUF_UPD_RESP: begin
        if (i_wr_resp) begin
          // Line lost between read and write goes back to the read
          w_state_next = i_wr_hit ? ST_BUF_WAIT_FINISH : ST_BUF_RD_L1D;
        end
      end
      ST_BUF_WAIT_FINISH: begin
        w_state_next = ST_BUF_INIT;
      end
      default: begin
        w_state_next = ST_BUF_INIT;
      end
    endcase
  end

  assign o_rd_req     = (r_state == ST_BUF_RD_L1D);
  assign o_wr_req     = (r_state == ST_BUF_L1D_UPDATE);
  assign o_refill_req = (r_state == ST_BUF_REFILL);

  // Bytes are frozen once the write is on its way
  assign o_mergeable = w_valid &
                       (r_state != ST_BUF_L1D_UPDATE) &
                       (r_state != ST_BUF_UPD_RESP) &
                       (r_state != ST_BUF_WAIT_FINISH);

  assign o_entry.valid = w_valid;
  assign o_entry.waddr = r_waddr;
  assign o_entry.data  = r_data;
  assign o_entry.strb  = r_strb;

endmodule

`default_nettype wire

/* src/stbuf_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module stbuf_ctrl
  import stbuf_pkg::*;
#(
  parameter int ENTRY_NUM = 4
) (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset_n,

  input  wire logic                 i_st_valid,
  input  wire logic [PADDR_W-1:0]   i_st_paddr,
  output logic                      o_st_ready,

  input  wire st_buffer_entry_t     i_entries [ENTRY_NUM],
  input  wire logic [ENTRY_NUM-1:0] i_mergeable,
  input  wire logic [ENTRY_NUM-1:0] i_rd_req,
  input  wire logic [ENTRY_NUM-1:0] i_wr_req,
  input  wire logic [ENTRY_NUM-1:0] i_refill_req,

  input  wire logic                 i_l1d_rd_ack,
  input  wire logic                 i_l1d_wr_ack,
  input  wire logic                 i_refill_ack,
  input  wire logic                 i_l1d_rd_resp,
  input  wire logic                 i_l1d_wr_resp,

  output logic [ENTRY_NUM-1:0]      o_load_oh,
  output logic [ENTRY_NUM-1:0]      o_merge_oh,
  output logic [ENTRY_NUM-1:0]      o_rd_accept_oh,
  output logic [ENTRY_NUM-1:0]      o_wr_accept_oh,
  output logic [ENTRY_NUM-1:0]      o_refill_accept_oh,
  output logic [ENTRY_NUM-1:0]      o_rd_resp_oh,
  output logic [ENTRY_NUM-1:0]      o_wr_resp_oh,

  output logic                      o_l1d_rd_req,
  output logic [PADDR_W-1:0]        o_l1d_rd_addr,
  output logic                      o_l1d_wr_req,
  output logic [PADDR_W-1:0]        o_l1d_wr_addr,
  output logic [DATA_W-1:0]         o_l1d_wr_data,
  output logic [DATA_B-1:0]         o_l1d_wr_strb,
  output logic                      o_refill_req,
  output logic [PADDR_W-1:0]        o_refill_addr
);

  function automatic logic [ENTRY_NUM-1:0] lowest_oh(input logic [ENTRY_NUM-1:0] vec);
    return vec & (~vec + 1'b1);
  endfunction

  logic [WADDR_W-1:0]   w_st_waddr;
  logic [ENTRY_NUM-1:0] w_match, w_free, w_free_oh;
  logic                 w_merge_hit, w_stall, w_st_fire;

  // --------------------
  // Allocation and merge
  // --------------------
  assign w_st_waddr = i_st_paddr[PADDR_W-1:WORD_OFS];

  always_comb begin
    for (int i = 0; i < ENTRY_NUM; i++) begin
      w_match[i] = i_entries[i].valid & (i_entries[i].waddr == w_st_waddr);
      w_free[i]  = ~i_entries[i].valid;
    end
  end

  assign w_free_oh   = lowest_oh(w_free);
  assign w_merge_hit = |(w_match & i_mergeable);
  assign w_stall     = |(w_match & ~i_mergeable);  // Keeps one word in order
  assign o_st_ready  = ~w_stall & (w_merge_hit | (|w_free));
  assign w_st_fire   = i_st_valid & o_st_ready;

  assign o_merge_oh = (w_st_fire & w_merge_hit)  ? (w_match & i_mergeable) : '0;
  assign o_load_oh  = (w_st_fire & ~w_merge_hit) ? w_free_oh : '0;

  // --------------------
  // Port arbitration
  // --------------------
  logic [ENTRY_NUM-1:0] r_rd_lock, r_wr_lock, r_rf_lock;  // Winner held under back-pressure
  logic [ENTRY_NUM-1:0] w_rd_grant, w_wr_grant, w_rf_grant;
  logic [ENTRY_NUM-1:0] r_rd_owner, r_wr_owner;           // Owner of the next response

  assign w_rd_grant = (r_rd_lock != '0) ? r_rd_lock : lowest_oh(i_rd_req);
  assign w_wr_grant = (r_wr_lock != '0) ? r_wr_lock : lowest_oh(i_wr_req);
  assign w_rf_grant = (r_rf_lock != '0) ? r_rf_lock : lowest_oh(i_refill_req);

  assign o_l1d_rd_req = |i_rd_req;
  assign o_l1d_wr_req = |i_wr_req;
  assign o_refill_req = |i_refill_req;

  assign o_rd_accept_oh     = i_l1d_rd_ack ? w_rd_grant : '0;
  assign o_wr_accept_oh     = i_l1d_wr_ack ? w_wr_grant : '0;
  assign o_refill_accept_oh = i_refill_ack ? w_rf_grant : '0;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rd_lock  <= '0;
      r_wr_lock  <= '0;
      r_rf_lock  <= '0;
      r_rd_owner <= '0;
      r_wr_owner <= '0;
    end else begin
      r_rd_lock <= (o_l1d_rd_req & ~i_l1d_rd_ack) ? w_rd_grant : '0;
      r_wr_lock <= (o_l1d_wr_req & ~i_l1d_wr_ack) ? w_wr_grant : '0;
      r_rf_lock <= (o_refill_req & ~i_refill_ack) ? w_rf_grant : '0;
      if (i_l1d_rd_ack) begin
        r_rd_owner <= w_rd_grant;
      end
      if (i_l1d_wr_ack) begin
        r_wr_owner <= w_wr_grant;
      end
    end
  end

  assign o_rd_resp_oh = i_l1d_rd_resp ? r_rd_owner : '0;
  assign o_wr_resp_oh = i_l1d_wr_resp ? r_wr_owner : '0;

  // AND-OR mux of the granted entry onto each port
  logic [WADDR_W-1:0] w_rd_waddr, w_wr_waddr, w_rf_waddr;

  always_comb begin
    w_rd_waddr    = '0;
    w_wr_waddr    = '0;
    w_rf_waddr    = '0;
    o_l1d_wr_data = '0;
    o_l1d_wr_strb = '0;
    for (int i = 0; i < ENTRY_NUM; i++) begin
      w_rd_waddr    |= w_rd_grant[i] ? i_entries[i].waddr : '0;
      w_wr_waddr    |= w_wr_grant[i] ? i_entries[i].waddr : '0;
      w_rf_waddr    |= w_rf_grant[i] ? i_entries[i].waddr : '0;
      o_l1d_wr_data |= w_wr_grant[i] ? i_entries[i].data  : '0;
      o_l1d_wr_strb |= w_wr_grant[i] ? i_entries[i].strb  : '0;
    end
  end

  assign o_l1d_rd_addr = {w_rd_waddr, {WORD_OFS{1'b0}}};
  assign o_l1d_wr_addr = {w_wr_waddr, {WORD_OFS{1'b0}}};
  assign o_refill_addr = {w_rf_waddr, {WORD_OFS{1'b0}}};

endmodule

`default_nettype wire

/* src/stbuf_fwd.sv */
`timescale 1ns/1ps
`default_nettype none

module stbuf_fwd
  import stbuf_pkg::*;
#(
  parameter int ENTRY_NUM = 4
) (
  input  wire st_buffer_entry_t   i_entries [ENTRY_NUM],
  input  wire logic               i_fwd_valid,
  input  wire logic [PADDR_W-1:0] i_fwd_paddr,
  output logic [DATA_B-1:0]       o_fwd_hit_strb,
  output logic [DATA_W-1:0]       o_fwd_data
);

  logic [WADDR_W-1:0]   w_fwd_waddr;
  logic [ENTRY_NUM-1:0] w_hit;

  assign w_fwd_waddr = i_fwd_paddr[PADDR_W-1:WORD_OFS];

  always_comb begin
    for (int i = 0; i < ENTRY_NUM; i++) begin
      w_hit[i] = i_fwd_valid & i_entries[i].valid &
                 (i_entries[i].waddr == w_fwd_waddr);
    end
  end

  // --------------------
  // Byte combine
  // --------------------
  // Only one live entry per word so the OR never mixes two owners
  always_comb begin
    o_fwd_hit_strb = '0;
    o_fwd_data     = '0;
    for (int i = 0; i < ENTRY_NUM; i++) begin
      for (int b = 0; b < DATA_B; b++) begin
        if (w_hit[i] & i_entries[i].strb[b]) begin
          o_fwd_hit_strb[b]    = 1'b1;
          o_fwd_data[b*8 +: 8] = o_fwd_data[b*8 +: 8] | i_entries[i].data[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/stbuf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stbuf_top
  import stbuf_pkg::*;
#(
  parameter int ENTRY_NUM = 4
) (
  input  wire logic               i_clk,
  input  wire logic               i_reset_n,

  // Retired stores
  input  wire logic               i_st_valid,
  input  wire logic [PADDR_W-1:0] i_st_paddr,
  input  wire logic [DATA_W-1:0]  i_st_data,
  input  wire logic [DATA_B-1:0]  i_st_strb,
  output logic                    o_st_ready,

  // L1D read
  output logic                    o_l1d_rd_req,
  output logic [PADDR_W-1:0]      o_l1d_rd_addr,
  input  wire logic               i_l1d_rd_ack,
  input  wire logic               i_l1d_rd_resp,
  input  wire logic               i_l1d_rd_hit,

  // L1D write
  output logic                    o_l1d_wr_req,
  output logic [PADDR_W-1:0]      o_l1d_wr_addr,
  output logic [DATA_W-1:0]       o_l1d_wr_data,
  output logic [DATA_B-1:0]       o_l1d_wr_strb,
  input  wire logic               i_l1d_wr_ack,
  input  wire logic               i_l1d_wr_resp,
  input  wire logic               i_l1d_wr_hit,

  // Refill
  output logic                    o_refill_req,
  output logic [PADDR_W-1:0]      o_refill_addr,
  input  wire logic               i_refill_ack,
  input  wire logic               i_refill_done,
  input  wire logic [PADDR_W-1:0] i_refill_addr,

  // Load forwarding
  input  wire logic               i_fwd_valid,
  input  wire logic [PADDR_W-1:0] i_fwd_paddr,
  output logic [DATA_B-1:0]       o_fwd_hit_strb,
  output logic [DATA_W-1:0]       o_fwd_data
);

  st_buffer_entry_t     w_entries [ENTRY_NUM];
  logic [ENTRY_NUM-1:0] w_mergeable, w_rd_req, w_wr_req, w_refill_req;
  logic [ENTRY_NUM-1:0] w_load_oh, w_merge_oh;
  logic [ENTRY_NUM-1:0] w_rd_accept_oh, w_wr_accept_oh, w_refill_accept_oh;
  logic [ENTRY_NUM-1:0] w_rd_resp_oh, w_wr_resp_oh;

  stbuf_ctrl #(
    .ENTRY_NUM (ENTRY_NUM)
  ) u_ctrl (
    .i_clk, .i_reset_n, .i_st_valid, .i_st_paddr, .o_st_ready,
    .i_entries (w_entries), .i_mergeable (w_mergeable),
    .i_rd_req (w_rd_req), .i_wr_req (w_wr_req), .i_refill_req (w_refill_req),
    .i_l1d_rd_ack, .i_l1d_wr_ack, .i_refill_ack, .i_l1d_rd_resp, .i_l1d_wr_resp,
    .o_load_oh (w_load_oh), .o_merge_oh (w_merge_oh),
    .o_rd_accept_oh (w_rd_accept_oh), .o_wr_accept_oh (w_wr_accept_oh),
    .o_refill_accept_oh (w_refill_accept_oh),
    .o_rd_resp_oh (w_rd_resp_oh), .o_wr_resp_oh (w_wr_resp_oh),
    .o_l1d_rd_req, .o_l1d_rd_addr, .o_l1d_wr_req, .o_l1d_wr_addr,
    .o_l1d_wr_data, .o_l1d_wr_strb, .o_refill_req, .o_refill_addr
  );

  for (genvar i = 0; i < ENTRY_NUM; i++) begin : g_entry
    stbuf_entry u_entry (
      .i_clk, .i_reset_n,
      .i_load (w_load_oh[i]), .i_merge_accept (w_merge_oh[i]),
      .i_st_paddr, .i_st_data, .i_st_strb,
      .i_rd_accepted (w_rd_accept_oh[i]), .i_rd_resp (w_rd_resp_oh[i]),
      .i_rd_hit (i_l1d_rd_hit),
      .i_wr_accepted (w_wr_accept_oh[i]), .i_wr_resp (w_wr_resp_oh[i]),
      .i_wr_hit (i_l1d_wr_hit),
      .i_refill_accepted (w_refill_accept_oh[i]), .i_refill_done, .i_refill_addr,
      .o_rd_req (w_rd_req[i]), .o_wr_req (w_wr_req[i]), .o_refill_req (w_refill_req[i]),
      .o_mergeable (w_mergeable[i]), .o_entry (w_entries[i])
    );
  end

  stbuf_fwd #(
    .ENTRY_NUM (ENTRY_NUM)
  ) u_fwd (
    .i_entries (w_entries), .i_fwd_valid, .i_fwd_paddr, .o_fwd_hit_strb, .o_fwd_data
  );

endmodule

`default_nettype wire

/* bench/stbuf_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module stbuf_asserts
  import stbuf_pkg::*;
#(
  parameter int ENTRY_NUM = 4
) (
  input wire logic                 i_clk,
  input wire logic                 i_reset_n,
  input wire logic                 i_rd_req,
  input wire logic [PADDR_W-1:0]   i_rd_addr,
  input wire logic                 i_rd_ack,
  input wire logic                 i_wr_req,
  input wire logic [PADDR_W-1:0]   i_wr_addr,
  input wire logic [DATA_W-1:0]    i_wr_data,
  input wire logic [DATA_B-1:0]    i_wr_strb,
  input wire logic                 i_wr_ack,
  input wire logic                 i_rf_req,
  input wire logic [PADDR_W-1:0]   i_rf_addr,
  input wire logic                 i_rf_ack,
  input wire logic [ENTRY_NUM-1:0] i_load_oh,
  input wire logic [ENTRY_NUM-1:0] i_merge_oh
);

  // --------------------
  // Request hold until ack
  // --------------------
  a_rd_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_rd_req && !i_rd_ack |=> i_rd_req && $stable(i_rd_addr))
    else $error("L1D read request dropped or moved before its ack");

  a_wr_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wr_req && !i_wr_ack |=> i_wr_req && $stable(i_wr_addr) &&
                              $stable(i_wr_data) && $stable(i_wr_strb))
    else $error("L1D write request dropped or changed before its ack");

  a_rf_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_rf_req && !i_rf_ack |=> i_rf_req && $stable(i_rf_addr))
    else $error("Refill request dropped or moved before its ack");

  // One allocation or merge per cycle at most
  a_one_store: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0({i_load_oh, i_merge_oh}))
    else $error("More than one entry loaded or merged in one cycle");

endmodule

bind stbuf_top stbuf_asserts #(
  .ENTRY_NUM (ENTRY_NUM)
) u_asserts (
  .i_clk, .i_reset_n,
  .i_rd_req (o_l1d_rd_req), .i_rd_addr (o_l1d_rd_addr), .i_rd_ack (i_l1d_rd_ack),
  .i_wr_req (o_l1d_wr_req), .i_wr_addr (o_l1d_wr_addr), .i_wr_data (o_l1d_wr_data),
  .i_wr_strb (o_l1d_wr_strb), .i_wr_ack (i_l1d_wr_ack),
  .i_rf_req (o_refill_req), .i_rf_addr (o_refill_addr), .i_rf_ack (i_refill_ack),
  .i_load_oh (w_load_oh), .i_merge_oh (w_merge_oh)
);

`default_nettype wire

/* bench/tb_stbuf.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_stbuf
  import stbuf_pkg::*;
();

  localparam int ENTRY_NUM  = 4;
  localparam int NUM_WORDS  = 6;   // Small pool so merges and stalls happen
  localparam int N_STORES   = 300;
  localparam real CLK_PERIOD = 100.0;
  localparam logic [PADDR_W-1:0] BASE_ADDR = 32'h0000_4000;

  logic i_clk, i_reset_n;
  logic i_st_valid, o_st_ready;
  logic [PADDR_W-1:0] i_st_paddr;
  logic [DATA_W-1:0]  i_st_data;
  logic [DATA_B-1:0]  i_st_strb;
  logic o_l1d_rd_req, i_l1d_rd_ack, i_l1d_rd_resp, i_l1d_rd_hit;
  logic [PADDR_W-1:0] o_l1d_rd_addr;
  logic o_l1d_wr_req, i_l1d_wr_ack, i_l1d_wr_resp, i_l1d_wr_hit;
  logic [PADDR_W-1:0] o_l1d_wr_addr;
  logic [DATA_W-1:0]  o_l1d_wr_data;
  logic [DATA_B-1:0]  o_l1d_wr_strb;
  logic o_refill_req, i_refill_ack, i_refill_done;
  logic [PADDR_W-1:0] o_refill_addr, i_refill_addr;
  logic i_fwd_valid;
  logic [PADDR_W-1:0] i_fwd_paddr;
  logic [DATA_B-1:0]  o_fwd_hit_strb;
  logic [DATA_W-1:0]  o_fwd_data;

  stbuf_top #(.ENTRY_NUM(ENTRY_NUM)) u_stbuf_top (.*);

  // --------------------
  // Model state
  // --------------------
  logic [DATA_W-1:0] pend_data [NUM_WORDS];  // Bytes not yet written to L1D
  logic [DATA_B-1:0] pend_strb [NUM_WORDS];
  logic [DATA_W-1:0] ref_img [NUM_WORDS];    // Last store wins
  logic [DATA_W-1:0] mem_img [NUM_WORDS];    // Built from the write port
  logic resident [NUM_WORDS];
  logic frozen [NUM_WORDS];                  // Read hit seen and write on its way
  logic miss_open [NUM_WORDS];
  int   rf_cnt [NUM_WORDS];
  logic [31:0] rd_word, wr_word, clr_word;
  logic [DATA_W-1:0] wr_data;
  logic [DATA_B-1:0] wr_strb;
  logic clr_pend;
  integer seed;
  int check_cnt, err_cnt, stores_done;

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] word_index(input logic [PADDR_W-1:0] a);
    return (a - BASE_ADDR) >> WORD_OFS;
  endfunction

  function automatic logic [DATA_W-1:0] expand_strb(input logic [DATA_B-1:0] s);
    logic [DATA_W-1:0] m;
    for (int b = 0; b < DATA_B; b++) begin
      m[b*8 +: 8] = {8{s[b]}};
    end
    return m;
  endfunction

  function automatic logic buffer_empty();
    logic empty;
    empty = !clr_pend;
    for (int k = 0; k < NUM_WORDS; k++) begin
      empty &= (pend_strb[k] == '0);
    end
    return empty;
  endfunction

  task automatic compare_hex(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    check_cnt++;
    assert (cond) else begin
      $display("ERROR: %s", what);
      err_cnt++;
    end
  endtask

  task automatic issue_store();
    i_st_valid <= 1'b1;
    i_st_paddr <= BASE_ADDR + rand_below(NUM_WORDS) * 8 + rand_below(8);
    i_st_data  <= {$random(seed), $random(seed)};
    i_st_strb  <= 1 + rand_below(255);  // Never zero
    @(posedge i_clk);
    while (!o_st_ready) begin
      @(posedge i_clk);
    end
    i_st_valid <= 1'b0;
    repeat (rand_below(3)) @(posedge i_clk);
  endtask

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // --------------------
  // Cache, refill and load-probe responder
  // --------------------
  always @(posedge i_clk) begin : responder
    logic [31:0] w;
    logic [DATA_W-1:0] m;
    logic exp_ready, found;
    int busy;
    if (i_reset_n) begin
      w = word_index(i_fwd_paddr);
      m = expand_strb(pend_strb[w]);
      compare_hex("o_fwd_hit_strb", o_fwd_hit_strb, i_fwd_valid ? pend_strb[w] : '0);
      if (i_fwd_valid) begin
        compare_hex("o_fwd_data", o_fwd_data & m, pend_data[w] & m);
      end
      if (i_st_valid) begin
        w = word_index(i_st_paddr);
        busy = 0;
        for (int k = 0; k < NUM_WORDS; k++) begin
          busy += (pend_strb[k] != '0);
        end
        exp_ready = (pend_strb[w] != '0) ? !frozen[w] : (busy < ENTRY_NUM);
        compare_hex("o_st_ready", o_st_ready, exp_ready);
        if (o_st_ready) begin
          m = expand_strb(i_st_strb);
          pend_data[w] = (pend_data[w] & ~m) | (i_st_data & m);
          ref_img[w]   = (ref_img[w] & ~m) | (i_st_data & m);
          pend_strb[w] |= i_st_strb;
          stores_done++;
        end
      end
      if (clr_pend) begin  // Entry has left its finish state
        pend_strb[clr_word] &= ~wr_strb;
        frozen[clr_word] = 1'b0;
        clr_pend = 1'b0;
      end
      // L1D read
      if (i_l1d_rd_resp) begin
        if (i_l1d_rd_hit) frozen[rd_word] = 1'b1;
        else miss_open[rd_word] = 1'b1;
      end
      if (o_l1d_rd_req && i_l1d_rd_ack) begin
        rd_word = word_index(o_l1d_rd_addr);
        expect_true(rd_word < NUM_WORDS, "L1D read address outside the word pool");
        i_l1d_rd_hit  <= resident[rd_word];
        i_l1d_rd_resp <= 1'b1;
        i_l1d_rd_ack  <= 1'b0;
      end else begin
        i_l1d_rd_resp <= 1'b0;
        i_l1d_rd_ack  <= o_l1d_rd_req && (rand_below(3) == 0);
      end
      // L1D write
      if (i_l1d_wr_resp) begin
        m = expand_strb(wr_strb);
        mem_img[wr_word] = (mem_img[wr_word] & ~m) | (wr_data & m);
        clr_word = wr_word;
        clr_pend = 1'b1;
      end
      if (o_l1d_wr_req && i_l1d_wr_ack) begin
        wr_word = word_index(o_l1d_wr_addr);
        m = expand_strb(pend_strb[wr_word]);
        compare_hex("o_l1d_wr_strb", o_l1d_wr_strb, pend_strb[wr_word]);
        compare_hex("o_l1d_wr_data", o_l1d_wr_data & m, pend_data[wr_word] & m);
        expect_true(resident[wr_word], "L1D write issued to a non-resident word");
        expect_true(!miss_open[wr_word], "L1D write after a miss with no refill request");
        expect_true(frozen[wr_word], "L1D write to a word with no read hit since its last write");
        wr_data = o_l1d_wr_data;
        wr_strb = o_l1d_wr_strb;
        i_l1d_wr_hit  <= resident[wr_word];
        i_l1d_wr_resp <= 1'b1;
        i_l1d_wr_ack  <= 1'b0;
      end else begin
        i_l1d_wr_resp <= 1'b0;
        i_l1d_wr_ack  <= o_l1d_wr_req && (rand_below(3) == 0);
      end
      // Refill with at most one done pulse per cycle
      found = 1'b0;
      for (int k = 0; k < NUM_WORDS; k++) begin
        if (rf_cnt[k] == 1 && !found) begin
          i_refill_addr <= BASE_ADDR + k * 8;
          resident[k] = 1'b1;
          rf_cnt[k] = 0;
          found = 1'b1;
        end else if (rf_cnt[k] > 1) begin
          rf_cnt[k]--;
        end
      end
      i_refill_done <= found;
      if (o_refill_req && i_refill_ack) begin
        w = word_index(o_refill_addr);
        expect_true(w < NUM_WORDS, "Refill address outside the word pool");
        miss_open[w] = 1'b0;
        rf_cnt[w] = 2 + rand_below(9);
        i_refill_ack <= 1'b0;
      end else begin
        i_refill_ack <= o_refill_req && (rand_below(3) == 0);
      end
      // Idle lines may be evicted
      w = rand_below(NUM_WORDS);
      if (rand_below(8) == 0 && pend_strb[w] == '0 && rf_cnt[w] == 0) begin
        resident[w] = 1'b0;
      end
      i_fwd_valid <= rand_below(2);
      i_fwd_paddr <= BASE_ADDR + rand_below(NUM_WORDS) * 8 + rand_below(8);
    end
  end

  initial begin : watchdog
    #((N_STORES * 200 + 1000) * CLK_PERIOD);
    $display("Timeout: stores did not drain within the allowed time");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : main
    int err_base;
    seed = 32'hb99046a9;
    {i_reset_n, i_st_valid, i_fwd_valid, i_refill_done} = '0;
    {i_l1d_rd_ack, i_l1d_rd_resp, i_l1d_rd_hit} = '0;
    {i_l1d_wr_ack, i_l1d_wr_resp, i_l1d_wr_hit, i_refill_ack} = '0;
    {i_st_paddr, i_st_data, i_st_strb, i_refill_addr, i_fwd_paddr} = '0;
    for (int k = 0; k < NUM_WORDS; k++) begin
      {pend_data[k], pend_strb[k], ref_img[k], mem_img[k]} = '0;
      {resident[k], frozen[k], miss_open[k]} = '0;  // Every word starts as a miss
      rf_cnt[k] = 0;
    end
    {clr_pend, rd_word, wr_word, clr_word, wr_data, wr_strb} = '0;
    {check_cnt, err_cnt, stores_done} = '0;
    repeat (8) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(posedge i_clk);
    err_base = err_cnt;
    compare_hex("o_l1d_rd_req", o_l1d_rd_req, 1'b0);
    compare_hex("o_l1d_wr_req", o_l1d_wr_req, 1'b0);
    compare_hex("o_refill_req", o_refill_req, 1'b0);
    compare_hex("o_fwd_hit_strb", o_fwd_hit_strb, '0);
    compare_hex("o_st_ready", o_st_ready, 1'b1);
    $display("Test reset_state done: %0d errors", err_cnt - err_base);
    err_base = err_cnt;
    repeat (N_STORES) issue_store();
    $display("Test random_traffic done: %0d stores taken, %0d errors",
             stores_done, err_cnt - err_base);
    err_base = err_cnt;
    do @(negedge i_clk); while (!buffer_empty());
    repeat (4) @(posedge i_clk);
    for (int k = 0; k < NUM_WORDS; k++) begin
      compare_hex($sformatf("mem_img[%0d]", k), mem_img[k], ref_img[k]);
    end
    $display("Test drain_memory done: %0d errors", err_cnt - err_base);
    $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
src/stbuf_pkg.sv
src/stbuf_entry.sv
src/stbuf_ctrl.sv
src/stbuf_fwd.sv
src/stbuf_top.sv
bench/stbuf_asserts.sv
bench/tb_stbuf.sv

/* Bender.yml */
package:
  name: stbuf

sources:
  - src/stbuf_pkg.sv
  - src/stbuf_entry.sv
  - src/stbuf_ctrl.sv
  - src/stbuf_fwd.sv
  - src/stbuf_top.sv
  - target: test
    files:
      - bench/stbuf_asserts.sv
      - bench/tb_stbuf.sv
